/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal --Mdir obj_dir
TOP      = rtWriteTb
FILELIST = compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with $(TOOL)"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+rtl
rtl/rtWritePkg.sv
rtl/rtQuadletIngress.sv
rtl/rtDacSequencer.sv
rtl/boardRegBank.sv
rtl/rtWriteTop.sv
dv/rtWriteTb.sv

/* dv/rtWriteTb.sv */
`timescale 1ns/1ps
`include "rtWrite_consts.svh"

module rtWriteTb;
   import rtWritePkg::*;

   localparam int NumMotors      = `RTW_NUM_MOTORS;
   localparam int CtrlBits       = `RTW_CTRL_BITS;
   localparam int Credits        = `RTW_CREDITS;
   localparam int NumPackets     = 60;
   localparam int WatchdogCycles = NumPackets * 300;
   localparam int DrainCycles    = 100;

   // Expected bank outputs right after one commitDone or powerWritten pulse
   typedef struct packed {
      logic                       isPower;
      logic [NumMotors-1:0][15:0] setpoint;
      logic [NumMotors-1:0]       amp;
      logic [CtrlBits-1:0]        power;
   } expEvent_t;

   logic                 clk;
   logic                 rstN;
   logic                 inValid;
   rtQuad_t              inQuad;
   logic                 creditReturn;
   logic [15:0]          dacSetpoint [NumMotors];
   logic [NumMotors-1:0] ampEnable;
   logic [CtrlBits-1:0]  powerCtrl;
   logic                 commitDone;
   logic                 powerWritten;

   rtQuad_t              txQueue [$];
   bit                   txBurst [$];
   expEvent_t            expQueue [$];
   int                   txIdx;
   int                   credits;
   logic                 sendEnable;
   // Reference model of the bank registers
   logic [15:0]          modelSet [NumMotors];
   logic [NumMotors-1:0] modelAmp;
   logic [CtrlBits-1:0]  modelPower;

   rtWriteTop u_rtWriteTop (
      .clk          (clk),
      .rstN         (rstN),
      .inValid      (inValid),
      .inQuad       (inQuad),
      .creditReturn (creditReturn),
      .dacSetpoint  (dacSetpoint),
      .ampEnable    (ampEnable),
      .powerCtrl    (powerCtrl),
      .commitDone   (commitDone),
      .powerWritten (powerWritten)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic checkSetpoint(input int idx, input logic [15:0] actual,
                                input logic [15:0] expected);
      if (actual !== expected)
         reportFailure($sformatf("Mismatch at %0t ns: dacSetpoint[%0d] is %h, expected %h",
                                 $time, idx, actual, expected));
   endtask

   task automatic checkAmpEnable(input logic [NumMotors-1:0] actual,
                                 input logic [NumMotors-1:0] expected);
      if (actual !== expected)
         reportFailure($sformatf("Mismatch at %0t ns: ampEnable is %b, expected %b",
                                 $time, actual, expected));
   endtask

   task automatic checkPowerCtrl(input logic [CtrlBits-1:0] actual,
                                 input logic [CtrlBits-1:0] expected);
      if (actual !== expected)
         reportFailure($sformatf("Mismatch at %0t ns: powerCtrl is %h, expected %h",
                                 $time, actual, expected));
   endtask

   task automatic checkOutputs(input expEvent_t ev);
      for (int i = 0; i < NumMotors; i++) begin
         checkSetpoint(i, dacSetpoint[i], ev.setpoint[i]);
      end
      checkAmpEnable(ampEnable, ev.amp);
      checkPowerCtrl(powerCtrl, ev.power);
   endtask

   function automatic expEvent_t modelSnapshot(input logic isPower);
      expEvent_t ev;
      ev.isPower = isPower;
      for (int i = 0; i < NumMotors; i++) begin
         ev.setpoint[i] = modelSet[i];
      end
      ev.amp   = modelAmp;
      ev.power = modelPower;
      return ev;
   endfunction

   // Random packets, with the expected pulse sequence worked out per packet
   task automatic buildPackets();
      logic [31:0]         dacQuads [NumMotors];
      logic [31:0]         ctrlQuad;
      logic [CtrlBits-1:0] field;
      logic                active;
      rtQuad_t             txWord;
      int                  mode;
      for (int p = 0; p < NumPackets; p++) begin
         // About a fifth of the packets hold no DAC update at all
         mode   = $urandom_range(0, 4);
         active = 1'b0;
         for (int ch = 0; ch < NumMotors; ch++) begin
            dacQuads[ch] = $urandom;
            if (mode == 0) begin
               dacQuads[ch][`RTW_VALID_BIT]   = 1'b0;
               dacQuads[ch][`RTW_AMPMASK_BIT] = 1'b0;
            end
            active      = active | dacQuads[ch][`RTW_VALID_BIT]
                          | dacQuads[ch][`RTW_AMPMASK_BIT];
            txWord.last = 1'b0;
            txWord.data = dacQuads[ch];
            txQueue.push_back(txWord);
            // Second half goes out back to back
            txBurst.push_back(p >= NumPackets / 2);
         end
         ctrlQuad = $urandom;
         if ($urandom_range(0, 3) == 0)
            ctrlQuad[CtrlBits-1:0] = '0;
         field       = ctrlQuad[CtrlBits-1:0];
         txWord.last = 1'b1;
         txWord.data = ctrlQuad;
         txQueue.push_back(txWord);
         txBurst.push_back(p >= NumPackets / 2);
         // Block commit applies only the flagged fields
         if (active) begin
            for (int ch = 0; ch < NumMotors; ch++) begin
               if (dacQuads[ch][`RTW_VALID_BIT])
                  modelSet[ch] = dacQuads[ch][15:0];
               if (dacQuads[ch][`RTW_AMPMASK_BIT])
                  modelAmp[ch] = dacQuads[ch][`RTW_AMPEN_BIT];
            end
            expQueue.push_back(modelSnapshot(1'b0));
         end
         // Power write after a block only when non-zero, always without one
         if (!active || field != '0) begin
            modelPower = field;
            expQueue.push_back(modelSnapshot(1'b1));
         end
      end
   endtask

   // Sender side of the credit link
   always @(posedge clk) begin
      if (!rstN) begin
         credits = Credits;
         txIdx   = 0;
         inValid <= 1'b0;
         inQuad  <= '0;
      end else begin
         if (creditReturn)
            credits = credits + 1;
         if (credits > Credits)
            reportFailure("Sender credits rose above the FIFO depth");
         if (sendEnable && txIdx < txQueue.size() && credits > 0
             && (txBurst[txIdx] || $urandom_range(0, 2) != 0)) begin
            inValid <= 1'b1;
            inQuad  <= txQueue[txIdx];
            txIdx   = txIdx + 1;
            credits = credits - 1;
         end else begin
            inValid <= 1'b0;
            inQuad  <= '0;
         end
      end
   end

   task automatic checkEvent(input logic isPower);
      expEvent_t ev;
      if (!sendEnable || expQueue.size() == 0) begin
         reportFailure($sformatf("%s pulsed at %0t ns with no write expected",
                                 isPower ? "powerWritten" : "commitDone", $time));
      end else begin
         ev = expQueue.pop_front();
         if (ev.isPower != isPower)
            reportFailure($sformatf("Mismatch at %0t ns: %s is 1, expected 0",
                                    $time, isPower ? "powerWritten" : "commitDone"));
         checkOutputs(ev);
      end
   endtask

   // Pulses and registers are stable at the falling edge
   always @(negedge clk) begin
      if (rstN) begin
         if (commitDone)
            checkEvent(1'b0);
         if (powerWritten)
            checkEvent(1'b1);
      end
   end

   initial begin
      repeat (WatchdogCycles) @(posedge clk);
      reportFailure($sformatf("Timeout after %0d cycles, %0d bank events never seen",
                              WatchdogCycles, expQueue.size()));
   end

   initial begin
      void'($urandom(95));
      rstN       = 1'b0;
      inValid    = 1'b0;
      inQuad     = '0;
      sendEnable = 1'b0;
      for (int i = 0; i < NumMotors; i++) begin
         modelSet[i] = '0;
      end
      modelAmp   = '0;
      modelPower = '0;
      buildPackets();
      repeat (4) @(posedge clk);
      rstN <= 1'b1;
      // Quiet period, everything reads zero
      repeat (10) @(negedge clk);
      checkOutputs('0);
      sendEnable = 1'b1;
      while (expQueue.size() != 0) @(posedge clk);
      // Catch stray pulses and late credit returns
      repeat (DrainCycles) @(negedge clk);
      checkOutputs(modelSnapshot(1'b0));
      if (txIdx != txQueue.size())
         reportFailure("Not every quadlet left the sender");
      else if (credits != Credits)
         reportFailure($sformatf("Sender holds %0d credits after drain, expected %0d",
                                 credits, Credits));
      else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* rtl/boardRegBank.sv */
`timescale 1ns/1ps
`include "rtWrite_consts.svh"

module boardRegBank (
   input  logic                        clk,
   input  logic                        rstN,
   input  rtWritePkg::boardWrite_t     boardWrite,
   output logic [15:0]                 dacSetpoint [`RTW_NUM_MOTORS],
   output logic [`RTW_NUM_MOTORS-1:0]  ampEnable,
   output logic [`RTW_CTRL_BITS-1:0]   powerCtrl,
   output logic                        commitDone,
   output logic                        powerWritten
);
   import rtWritePkg::*;

   localparam int NumMotors = `RTW_NUM_MOTORS;

   logic [31:0]               stagedQuad [NumMotors];
   logic [NumMotors-1:0]      stagedVal;
   logic [`RTW_CHAN_BITS-1:0] chanIdx;
   logic                      chanWrite;
   logic                      powerWrite;
   logic                      commit;
   logic                      committed;

   // Decode the bus cycle
   assign chanIdx    = boardWrite.regAddr[4 +: `RTW_CHAN_BITS];
   assign chanWrite  = boardWrite.regWen
                       && (boardWrite.regAddr[3:0] == `RTW_OFF_DAC_CTRL)
                       && (boardWrite.regAddr[7:4] < 4'(NumMotors));
   assign powerWrite = boardWrite.regWen && (boardWrite.regAddr == 8'h00);
   // blockWen alone ends a DAC block
   assign commit     = boardWrite.blockWen && !boardWrite.regWen;

   // Staged quadlets
   always_ff @(posedge clk) begin
      if (chanWrite)
         stagedQuad[chanIdx] <= boardWrite.regData;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         stagedVal    <= '0;
         committed    <= 1'b0;
         ampEnable    <= '0;
         powerCtrl    <= '0;
         commitDone   <= 1'b0;
         powerWritten <= 1'b0;
         for (int i = 0; i < NumMotors; i++) begin
            dacSetpoint[i] <= '0;
         end
      end else begin
         commitDone   <= commit;
         powerWritten <= powerWrite;
         if (boardWrite.blockStart) begin
            stagedVal <= '0;
            committed <= 1'b0;
         end else if (chanWrite) begin
            stagedVal[chanIdx] <= 1'b1;
         end
         if (commit) begin
            // Apply only the fields flagged in each staged quadlet
            for (int i = 0; i < NumMotors; i++) begin
               if (stagedVal[i] && stagedQuad[i][`RTW_VALID_BIT])
                  dacSetpoint[i] <= stagedQuad[i][15:0];
               if (stagedVal[i] && stagedQuad[i][`RTW_AMPMASK_BIT])
                  ampEnable[i] <= stagedQuad[i][`RTW_AMPEN_BIT];
            end
            stagedVal <= '0;
            committed <= 1'b1;
         end
         if (powerWrite)
            powerCtrl <= boardWrite.regData[`RTW_CTRL_BITS-1:0];
      end
   end

   // A new block must open with blockStart before more channel writes
   aNoStageAfterCommit: assert property (@(posedge clk) disable iff (!rstN)
      !(committed && chanWrite && !boardWrite.blockStart));

endmodule

/* rtl/rtDacSequencer.sv */
`timescale 1ns/1ps
`include "rtWrite_consts.svh"

module rtDacSequencer (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     slotValid,
   input  rtWritePkg::rtSlotWrite_t slotWrite,
   output logic                     seqReady,
   output rtWritePkg::boardWrite_t  boardWrite
);
   import rtWritePkg::*;

   localparam int NumMotors = `RTW_NUM_MOTORS;
   localparam int GapCycles = `RTW_GAP_CYCLES;
   localparam int GapW      = (GapCycles > 1) ? $clog2(GapCycles) : 1;

   rtSeqState_t                state;
   logic [GapW-1:0]            gapCnt;
   logic                       gapDone;
   logic [`RTW_CHAN_BITS-1:0]  chan;
   logic [31:0]                dacMem [NumMotors];
   logic [`RTW_CTRL_BITS-1:0]  ctrlKeep;
   logic                       anyActive;
   logic                       take;

   // Only accept quadlets between sequences
   assign seqReady = (state == Idle);
   assign take     = slotValid && seqReady;
   assign gapDone  = (gapCnt == GapW'(GapCycles - 1));

   // Any channel with a setpoint or an amp-enable change pending
   always_comb begin
      anyActive = 1'b0;
      for (int i = 0; i < NumMotors; i++) begin
         anyActive = anyActive | dacMem[i][`RTW_VALID_BIT] | dacMem[i][`RTW_AMPMASK_BIT];
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state      <= Idle;
         gapCnt     <= '0;
         chan       <= '0;
         ctrlKeep   <= '0;
         boardWrite <= '0;
         // Clear the pending flags of every channel
         for (int i = 0; i < NumMotors; i++) begin
            dacMem[i][`RTW_VALID_BIT]   <= 1'b0;
            dacMem[i][`RTW_AMPMASK_BIT] <= 1'b0;
         end
      end else begin
         // Phase timer runs outside Idle and wraps at the end of each phase
         gapCnt <= (state == Idle || gapDone) ? '0 : gapCnt + 1'b1;

         case (state)
            Idle: begin
               boardWrite.regWen     <= 1'b0;
               boardWrite.blockWen   <= 1'b0;
               boardWrite.blockStart <= 1'b0;
               if (take) begin
                  if (slotWrite.isCtrl) begin
                     // Keep only the safe low field of the power quadlet
                     ctrlKeep <= slotWrite.data[`RTW_CTRL_BITS-1:0];
                     if (anyActive) begin
                        boardWrite.blockStart <= 1'b1;
                        state                 <= BlockStart;
                     end else begin
                        // No DAC update pending so only the power quadlet goes out
                        state <= Quad;
                     end
                  end else begin
                     dacMem[slotWrite.slot[`RTW_CHAN_BITS-1:0]] <= slotWrite.data;
                  end
               end
            end

            BlockStart: begin
               // blockStart held for one full phase
               if (gapDone) begin
                  boardWrite.blockStart <= 1'b0;
                  chan                  <= '0;
                  state                 <= Write;
               end
            end

            Write: begin
               boardWrite.regWen  <= 1'b1;
               boardWrite.regAddr <= {4'(chan), `RTW_OFF_DAC_CTRL};
               boardWrite.regData <= dacMem[chan];
               state              <= WriteGap;
            end

            WriteGap: begin
               boardWrite.regWen <= 1'b0;
               // Drop the pending flags of the written channel
               dacMem[chan][`RTW_VALID_BIT]   <= 1'b0;
               dacMem[chan][`RTW_AMPMASK_BIT] <= 1'b0;
               if (gapDone) begin
                  if (chan == `RTW_CHAN_BITS'(NumMotors - 1)) begin
                     state <= BlockWen;
                  end else begin
                     chan  <= chan + 1'b1;
                     state <= Write;
                  end
               end
            end

            BlockWen: begin
               if (gapDone) begin
                  boardWrite.blockWen <= 1'b1;
                  // Power quadlet follows a block only when non-zero
                  state <= (ctrlKeep == '0) ? Idle : QuadGap;
               end
            end

            QuadGap: begin
               boardWrite.blockWen <= 1'b0;
               if (gapDone)
                  state <= Quad;
            end

            Quad: begin
               // regWen with blockWen at address 0 is the power write
               boardWrite.regAddr  <= 8'h00;
               boardWrite.regData  <= 32'(ctrlKeep);
               boardWrite.regWen   <= 1'b1;
               boardWrite.blockWen <= 1'b1;
               ctrlKeep            <= '0;
               state               <= Idle;
            end

            default: state <= Idle;
         endcase
      end
   end

   aNoRegWenInStart: assert property (@(posedge clk) disable iff (!rstN)
      !(boardWrite.regWen && boardWrite.blockStart));

   // Every stored channel write has gone out once the write phases are over
   aNoStoredAfterWrites: assert property (@(posedge clk) disable iff (!rstN)
      (state inside {BlockWen, QuadGap, Quad}) |-> !anyActive);

   aStateLegal: assert property (@(posedge clk) disable iff (!rstN)
      state inside {Idle, BlockStart, Write, WriteGap, BlockWen, QuadGap, Quad});

endmodule

/* rtl/rtQuadletIngress.sv */
`timescale 1ns/1ps
`include "rtWrite_consts.svh"

module rtQuadletIngress (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic                     inValid,
   input  rtWritePkg::rtQuad_t      inQuad,
   output logic                     creditReturn,
   output logic                     slotValid,
   output rtWritePkg::rtSlotWrite_t slotWrite,
   input  logic                     seqReady
);
   import rtWritePkg::*;

   localparam int Depth = `RTW_CREDITS;
   localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
   localparam int CntW  = $clog2(Depth + 1);

   rtSlotWrite_t            fifoMem [Depth];
   rtSlotWrite_t            pushEntry;
   logic [PtrW-1:0]         wrPtr;
   logic [PtrW-1:0]         rdPtr;
   logic [CntW-1:0]         fillCnt;
   logic [`RTW_CHAN_BITS:0] slotCnt;
   logic                    push;
   logic                    pop;
   logic                    full;

   // Sender only pushes with a credit in hand
   assign push = inValid;
   // Pop is the handshake with the sequencer
   assign pop  = slotValid && seqReady;
   assign full = (fillCnt == CntW'(Depth));

   assign slotValid = (fillCnt != '0);
   assign slotWrite = fifoMem[rdPtr];

   // Tag the quadlet with its position in the packet
   always_comb begin
      pushEntry.data   = inQuad.data;
      pushEntry.slot   = slotCnt;
      pushEntry.isCtrl = inQuad.last;
   end

   always_ff @(posedge clk) begin
      if (push)
         fifoMem[wrPtr] <= pushEntry;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wrPtr        <= '0;
         rdPtr        <= '0;
         fillCnt      <= '0;
         slotCnt      <= '0;
         creditReturn <= 1'b0;
      end else begin
         // One credit back per popped quadlet
         creditReturn <= pop;
         if (push) begin
            wrPtr   <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            // Last flag closes the packet, numbering restarts
            slotCnt <= inQuad.last ? '0 : slotCnt + 1'b1;
         end
         if (pop)
            rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
         case ({push, pop})
            2'b10:   fillCnt <= fillCnt + 1'b1;
            2'b01:   fillCnt <= fillCnt - 1'b1;
            default: fillCnt <= fillCnt;
         endcase
      end
   end

   // Credit rule keeps the sender from overrunning the FIFO
   aPushNotFull: assert property (@(posedge clk) disable iff (!rstN)
      !(push && full));

   // Control quadlet comes right after the DAC quadlets
   aLastAtCtrlSlot: assert property (@(posedge clk) disable iff (!rstN)
      (push && inQuad.last) |-> (slotCnt == (`RTW_CHAN_BITS + 1)'(`RTW_NUM_MOTORS)));

endmodule

/* rtl/rtWritePkg.sv */
`include "rtWrite_consts.svh"

package rtWritePkg;

   // One quadlet on the credit link
   typedef struct packed {
      logic        last;
      logic [31:0] data;
   } rtQuad_t;

   // Quadlet tagged with its slot in the packet
   // Slot NUM_MOTORS carries the power-control quadlet
   typedef struct packed {
      logic [31:0]              data;
      logic [`RTW_CHAN_BITS:0]  slot;
      logic                     isCtrl;
   } rtSlotWrite_t;

   // Board bus write bundle
   // regAddr high nibble is the channel, low nibble the register offset
   typedef struct packed {
      logic        regWen;
      logic        blockWen;
      logic        blockStart;
      logic [7:0]  regAddr;
      logic [31:0] regData;
   } boardWrite_t;

   // Sequencer states
   typedef enum logic [2:0] {
      Idle,
      BlockStart,
      Write,
      WriteGap,
      BlockWen,
      QuadGap,
      Quad
   } rtSeqState_t;

endpackage

/* rtl/rtWriteTop.sv */
`timescale 1ns/1ps
`include "rtWrite_consts.svh"

module rtWriteTop (
   input  logic                        clk,
   input  logic                        rstN,
   input  logic                        inValid,
   input  rtWritePkg::rtQuad_t         inQuad,
   output logic                        creditReturn,
   output logic [15:0]                 dacSetpoint [`RTW_NUM_MOTORS],
   output logic [`RTW_NUM_MOTORS-1:0]  ampEnable,
   output logic [`RTW_CTRL_BITS-1:0]   powerCtrl,
   output logic                        commitDone,
   output logic                        powerWritten
);
   import rtWritePkg::*;

   rtSlotWrite_t slotWrite;
   logic         slotValid;
   logic         seqReady;
   boardWrite_t  boardWrite;

   // Credit link in, slot-numbered quadlets out
   rtQuadletIngress u_rtQuadletIngress (
      .clk          (clk),
      .rstN         (rstN),
      .inValid      (inValid),
      .inQuad       (inQuad),
      .creditReturn (creditReturn),
      .slotValid    (slotValid),
      .slotWrite    (slotWrite),
      .seqReady     (seqReady)
   );

   // Stores the block and plays out the board bus sequence
   rtDacSequencer u_rtDacSequencer (
      .clk        (clk),
      .rstN       (rstN),
      .slotValid  (slotValid),
      .slotWrite  (slotWrite),
      .seqReady   (seqReady),
      .boardWrite (boardWrite)
   );

   boardRegBank u_boardRegBank (
      .clk          (clk),
      .rstN         (rstN),
      .boardWrite   (boardWrite),
      .dacSetpoint  (dacSetpoint),
      .ampEnable    (ampEnable),
      .powerCtrl    (powerCtrl),
      .commitDone   (commitDone),
      .powerWritten (powerWritten)
   );

endmodule

/* rtl/rtWrite_consts.svh */
`ifndef RTWRITE_CONSTS_SVH
`define RTWRITE_CONSTS_SVH

// Channel count, only 4 or 8 supported
`define RTW_NUM_MOTORS    4
// Must cover RTW_NUM_MOTORS-1
`define RTW_CHAN_BITS     2
// Ingress FIFO depth and sender credits after reset
`define RTW_CREDITS       4
// Field positions in a DAC quadlet
`define RTW_VALID_BIT     31
`define RTW_AMPMASK_BIT   29
`define RTW_AMPEN_BIT     28
// Only the low bits of the power quadlet are kept
`define RTW_CTRL_BITS     20
// Low nibble of a channel DAC register, never 0 since address 0 is power control
`define RTW_OFF_DAC_CTRL  4'h1
// Length of every timed phase on the board bus
`define RTW_GAP_CYCLES    4

`endif
